// File: source/cov_pkg.sv
package cov_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [31:0] cycle_count_t;
    typedef logic [5:0]  cov_count_t;

    // Register map of the cosine slave
    localparam addr_t ADDR_BASIC_MIN  = 32'h0000_0000;
    localparam addr_t ADDR_BASIC_MAX  = 32'h0000_000C;
    localparam addr_t ADDR_COS_CTRL   = 32'h0000_0020;
    localparam addr_t ADDR_COS_DATA   = 32'h0000_0024;
    localparam addr_t ADDR_COS_STATUS = 32'h0000_0028;

    // Page in PADDR[7:4], offset in PADDR[3:0]
    localparam logic [3:0] PAGE_BASIC = 4'h0;
    localparam logic [3:0] PAGE_COS   = 4'h2;
    localparam logic [3:0] OFS_CTRL   = 4'h0;
    localparam logic [3:0] OFS_DATA   = 4'h4;
    localparam logic [3:0] OFS_STATUS = 4'h8;

    // Q16 results for +1 and -1
    localparam data_t COS_PLUS_ONE  = 32'h0001_0000;
    localparam data_t COS_MINUS_ONE = 32'hFFFF_0000;

    localparam int BIN_TOTAL = 43;

    typedef enum logic [1:0] {
        M_IDLE   = 2'd0,
        M_SETUP  = 2'd1,
        M_ACCESS = 2'd2
    } master_state_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        data_t pwdata;
        logic  pready;
    } apb_bus_t;

    typedef struct packed {
        data_t cos_data;
        logic  start_calculation;
        logic  calculation_done;
    } cos_side_t;

    typedef struct packed {
        master_state_t master_state;
        logic          transaction_active;
    } master_side_t;

    typedef struct packed {
        logic cond_pready;
        logic cond_psel_penable;
        logic cond_pwrite;
        logic cond_start_calc;
        logic wr_basic;
        logic wr_cos_ctrl;
        logic wr_cos_data;
        logic rd_basic;
        logic rd_cos_ctrl;
        logic rd_cos_data;
        logic rd_status;
        logic fn_write;
        logic fn_read;
        logic fn_cos_calc;
        logic addr_min;
        logic addr_max_basic;
        logic addr_cos_ctrl;
        logic addr_cos_data;
        logic addr_cos_status;
        logic data_zero;
        logic data_max;
        logic cos_plus_one;
        logic cos_minus_one;
    } apb_hits_t;

    typedef struct packed {
        logic cond_transaction;
        logic br_idle_setup;
        logic br_setup_access;
        logic br_access_idle;
        logic seen_idle;
        logic seen_setup;
        logic seen_access;
        logic tr_idle_setup;
        logic tr_setup_access;
        logic tr_access_idle;
    } fsm_hits_t;

    typedef struct packed {
        logic psel_rise;
        logic psel_fall;
        logic penable_rise;
        logic penable_fall;
        logic pwrite_rise;
        logic pwrite_fall;
        logic start_rise;
        logic start_fall;
        logic done_rise;
        logic done_fall;
    } toggle_hits_t;

endpackage

// File: source/apb_access_bins.sv
module apb_access_bins
    import cov_pkg::*;
(
    input  logic      PCLK,
    input  logic      PRESETn,
    input  apb_bus_t  bus,
    input  cos_side_t cos,
    output apb_hits_t hits
);

    logic       access;
    logic [3:0] page;
    logic [3:0] offset;
    apb_hits_t  set_now;

    assign access = bus.psel && bus.penable;
    assign page   = bus.paddr[7:4];
    assign offset = bus.paddr[3:0];

    always_comb begin
        set_now = '0;

        set_now.cond_pready       = bus.pready;
        set_now.cond_psel_penable = access;
        set_now.cond_pwrite       = bus.pwrite;
        set_now.cond_start_calc   = cos.start_calculation;

        // Slave write decode
        if (access && bus.pwrite) begin
            if (page == PAGE_BASIC) begin
                set_now.wr_basic = 1'b1;
            end else if (page == PAGE_COS) begin
                if (offset == OFS_CTRL) begin
                    set_now.wr_cos_ctrl = 1'b1;
                end else if (offset == OFS_DATA) begin
                    set_now.wr_cos_data = 1'b1;
                end
            end
        end

        // Slave read decode including the read only status
        if (access && !bus.pwrite) begin
            if (page == PAGE_BASIC) begin
                set_now.rd_basic = 1'b1;
            end else if (page == PAGE_COS) begin
                if (offset == OFS_CTRL) begin
                    set_now.rd_cos_ctrl = 1'b1;
                end else if (offset == OFS_DATA) begin
                    set_now.rd_cos_data = 1'b1;
                end else if (offset == OFS_STATUS) begin
                    set_now.rd_status = 1'b1;
                end
            end
        end

        set_now.fn_write    = access && bus.pwrite;
        set_now.fn_read     = access && !bus.pwrite;
        set_now.fn_cos_calc = cos.start_calculation && !cos.calculation_done;

        // Boundary addresses
        set_now.addr_min        = (bus.paddr == ADDR_BASIC_MIN);
        set_now.addr_max_basic  = (bus.paddr == ADDR_BASIC_MAX);
        set_now.addr_cos_ctrl   = (bus.paddr == ADDR_COS_CTRL);
        set_now.addr_cos_data   = (bus.paddr == ADDR_COS_DATA);
        set_now.addr_cos_status = (bus.paddr == ADDR_COS_STATUS);

        // Boundary data and cos results
        set_now.data_zero     = (bus.pwdata == '0);
        set_now.data_max      = (bus.pwdata == '1);
        set_now.cos_plus_one  = (cos.cos_data == COS_PLUS_ONE);
        set_now.cos_minus_one = (cos.cos_data == COS_MINUS_ONE);
    end

    // Sticky until reset
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            hits <= '0;
        end else begin
            hits <= hits | set_now;
        end
    end

endmodule

// File: source/master_fsm_bins.sv
module master_fsm_bins
    import cov_pkg::*;
(
    input  logic         PCLK,
    input  logic         PRESETn,
    input  master_side_t master,
    input  logic         pready,
    output fsm_hits_t    hits,
    output cycle_count_t idle_cycles,
    output cycle_count_t setup_cycles,
    output cycle_count_t access_cycles
);

    master_state_t state;
    master_state_t prev_state;
    fsm_hits_t     set_now;

    assign state = master.master_state;

    always_comb begin
        set_now = '0;

        set_now.cond_transaction = master.transaction_active;

        // Branches taken inside the master FSM
        set_now.br_idle_setup   = (state == M_IDLE) && master.transaction_active;
        set_now.br_setup_access = (state == M_SETUP);
        set_now.br_access_idle  = (state == M_ACCESS) && pready;

        set_now.seen_idle   = (state == M_IDLE);
        set_now.seen_setup  = (state == M_SETUP);
        set_now.seen_access = (state == M_ACCESS);

        set_now.tr_idle_setup   = (prev_state == M_IDLE) && (state == M_SETUP);
        set_now.tr_setup_access = (prev_state == M_SETUP) && (state == M_ACCESS);
        set_now.tr_access_idle  = (prev_state == M_ACCESS) && (state == M_IDLE);
    end

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            hits       <= '0;
            prev_state <= M_IDLE;
        end else begin
            hits       <= hits | set_now;
            prev_state <= state;
        end
    end

    // Cycles spent in each state except the unused value 3
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            idle_cycles   <= '0;
            setup_cycles  <= '0;
            access_cycles <= '0;
        end else begin
            case (state)
                M_IDLE:   idle_cycles   <= idle_cycles + 1'b1;
                M_SETUP:  setup_cycles  <= setup_cycles + 1'b1;
                M_ACCESS: access_cycles <= access_cycles + 1'b1;
                default: begin
                end
            endcase
        end
    end

endmodule

// File: source/toggle_bins.sv
module toggle_bins
    import cov_pkg::*;
(
    input  logic         PCLK,
    input  logic         PRESETn,
    input  apb_bus_t     bus,
    input  cos_side_t    cos,
    output toggle_hits_t hits
);

    // Order is psel, penable, pwrite, start, done
    logic [4:0]   cur;
    logic [4:0]   prev;
    logic [4:0]   rise;
    logic [4:0]   fall;
    toggle_hits_t set_now;

    assign cur = {bus.psel, bus.penable, bus.pwrite,
                  cos.start_calculation, cos.calculation_done};

    assign rise = cur & ~prev;
    assign fall = ~cur & prev;

    assign set_now = '{
        psel_rise:    rise[4],
        psel_fall:    fall[4],
        penable_rise: rise[3],
        penable_fall: fall[3],
        pwrite_rise:  rise[2],
        pwrite_fall:  fall[2],
        start_rise:   rise[1],
        start_fall:   fall[1],
        done_rise:    rise[0],
        done_fall:    fall[0]
    };

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            prev <= '0;
            hits <= '0;
        end else begin
            prev <= cur;
            hits <= hits | set_now;
        end
    end

endmodule

// File: source/coverage_tally.sv
module coverage_tally
    import cov_pkg::*;
(
    input  logic         PCLK,
    input  logic         PRESETn,
    input  apb_hits_t    apb_hits,
    input  fsm_hits_t    fsm_hits,
    input  toggle_hits_t toggle_hits,
    output cov_count_t   covered,
    output logic         complete
);

    logic [BIN_TOTAL-1:0] all_hits;
    cov_count_t           count_now;

    assign all_hits = {apb_hits, fsm_hits, toggle_hits};

    // Popcount over every bin
    always_comb begin
        count_now = '0;
        for (int i = 0; i < BIN_TOTAL; i++) begin
            count_now = count_now + cov_count_t'(all_hits[i]);
        end
    end

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            covered <= '0;
        end else begin
            covered <= count_now;
        end
    end

    assign complete = (covered == cov_count_t'(BIN_TOTAL));

endmodule

// File: source/coverage_collector.sv
module coverage_collector
    import cov_pkg::*;
(
    input  logic         PCLK,
    input  logic         PRESETn,
    input  logic         PSEL,
    input  logic         PENABLE,
    input  logic         PWRITE,
    input  addr_t        PADDR,
    input  data_t        PWDATA,
    input  logic         PREADY,
    input  data_t        cos_data_reg,
    input  logic         start_calculation,
    input  logic         calculation_done,
    input  logic [1:0]   master_state,
    input  logic         transaction_active,
    output apb_hits_t    apb_hits,
    output fsm_hits_t    fsm_hits,
    output toggle_hits_t toggle_hits,
    output cycle_count_t idle_cycles,
    output cycle_count_t setup_cycles,
    output cycle_count_t access_cycles,
    output cov_count_t   covered,
    output logic         complete
);

    apb_bus_t     bus;
    cos_side_t    cos;
    master_side_t master;

    assign bus = '{
        psel:    PSEL,
        penable: PENABLE,
        pwrite:  PWRITE,
        paddr:   PADDR,
        pwdata:  PWDATA,
        pready:  PREADY
    };

    assign cos = '{
        cos_data:          cos_data_reg,
        start_calculation: start_calculation,
        calculation_done:  calculation_done
    };

    assign master = '{
        master_state:       master_state_t'(master_state),
        transaction_active: transaction_active
    };

    apb_access_bins apb_bins_i (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .bus     (bus),
        .cos     (cos),
        .hits    (apb_hits)
    );

    master_fsm_bins fsm_bins_i (
        .PCLK          (PCLK),
        .PRESETn       (PRESETn),
        .master        (master),
        .pready        (PREADY),
        .hits          (fsm_hits),
        .idle_cycles   (idle_cycles),
        .setup_cycles  (setup_cycles),
        .access_cycles (access_cycles)
    );

    toggle_bins toggle_bins_i (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .bus     (bus),
        .cos     (cos),
        .hits    (toggle_hits)
    );

    coverage_tally tally_i (
        .PCLK        (PCLK),
        .PRESETn     (PRESETn),
        .apb_hits    (apb_hits),
        .fsm_hits    (fsm_hits),
        .toggle_hits (toggle_hits),
        .covered     (covered),
        .complete    (complete)
    );

endmodule

// File: testbench/tb_coverage_collector.sv
module tb_coverage_collector
    import cov_pkg::*;
();

    logic         PCLK;
    logic         PRESETn;
    logic         PSEL;
    logic         PENABLE;
    logic         PWRITE;
    addr_t        PADDR;
    data_t        PWDATA;
    logic         PREADY;
    data_t        cos_data_reg;
    logic         start_calculation;
    logic         calculation_done;
    logic [1:0]   master_state;
    logic         transaction_active;
    apb_hits_t    apb_hits;
    fsm_hits_t    fsm_hits;
    toggle_hits_t toggle_hits;
    cycle_count_t idle_cycles;
    cycle_count_t setup_cycles;
    cycle_count_t access_cycles;
    cov_count_t   covered;
    logic         complete;

    // Reference model state
    apb_hits_t    exp_apb;
    fsm_hits_t    exp_fsm;
    toggle_hits_t exp_tog;
    cycle_count_t exp_idle;
    cycle_count_t exp_setup;
    cycle_count_t exp_access;
    cov_count_t   exp_covered;
    logic [1:0]   exp_prev_state;
    logic [4:0]   exp_prev_bits;
    logic         model_live;
    integer       seed;

    coverage_collector dut_i (.*);

    always #50 PCLK = ~PCLK;

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_apb_hits(apb_hits_t got, apb_hits_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: apb_hits is %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_fsm_hits(fsm_hits_t got, fsm_hits_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: fsm_hits is %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_toggle_hits(toggle_hits_t got, toggle_hits_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: toggle_hits is %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_cycles(string name, cycle_count_t got, cycle_count_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_count(cov_count_t got, cov_count_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: covered is %0d, expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    function void model_reset();
        exp_apb        = '0;
        exp_fsm        = '0;
        exp_tog        = '0;
        exp_idle       = '0;
        exp_setup      = '0;
        exp_access     = '0;
        exp_covered    = '0;
        exp_prev_state = M_IDLE;
        exp_prev_bits  = '0;
    endfunction

    // One rising edge of the bin rules
    function void model_step();
        logic         acc;
        logic         cos_page;
        logic [3:0]   ofs;
        logic [4:0]   now_bits;
        apb_hits_t    a;
        fsm_hits_t    f;
        toggle_hits_t t;
        // Count trails the flags by one edge
        exp_covered = cov_count_t'($countones({exp_apb, exp_fsm, exp_tog}));
        acc      = PSEL & PENABLE;
        cos_page = (PADDR[7:4] == PAGE_COS);
        ofs      = PADDR[3:0];
        a = '0;
        a.cond_pready       = PREADY;
        a.cond_psel_penable = acc;
        a.cond_pwrite       = PWRITE;
        a.cond_start_calc   = start_calculation;
        a.fn_write          = acc & PWRITE;
        a.fn_read           = acc & ~PWRITE;
        a.fn_cos_calc       = start_calculation & ~calculation_done;
        a.wr_basic          = a.fn_write & (PADDR[7:4] == PAGE_BASIC);
        a.wr_cos_ctrl       = a.fn_write & cos_page & (ofs == OFS_CTRL);
        a.wr_cos_data       = a.fn_write & cos_page & (ofs == OFS_DATA);
        a.rd_basic          = a.fn_read & (PADDR[7:4] == PAGE_BASIC);
        a.rd_cos_ctrl       = a.fn_read & cos_page & (ofs == OFS_CTRL);
        a.rd_cos_data       = a.fn_read & cos_page & (ofs == OFS_DATA);
        a.rd_status         = a.fn_read & cos_page & (ofs == OFS_STATUS);
        a.addr_min          = (PADDR == ADDR_BASIC_MIN);
        a.addr_max_basic    = (PADDR == ADDR_BASIC_MAX);
        a.addr_cos_ctrl     = (PADDR == ADDR_COS_CTRL);
        a.addr_cos_data     = (PADDR == ADDR_COS_DATA);
        a.addr_cos_status   = (PADDR == ADDR_COS_STATUS);
        a.data_zero         = (PWDATA == 32'h0);
        a.data_max          = (PWDATA == 32'hFFFF_FFFF);
        a.cos_plus_one      = (cos_data_reg == COS_PLUS_ONE);
        a.cos_minus_one     = (cos_data_reg == COS_MINUS_ONE);
        exp_apb = exp_apb | a;

        f = '0;
        f.cond_transaction = transaction_active;
        f.br_idle_setup    = (master_state == M_IDLE) & transaction_active;
        f.br_setup_access  = (master_state == M_SETUP);
        f.br_access_idle   = (master_state == M_ACCESS) & PREADY;
        f.seen_idle        = (master_state == M_IDLE);
        f.seen_setup       = (master_state == M_SETUP);
        f.seen_access      = (master_state == M_ACCESS);
        f.tr_idle_setup    = (exp_prev_state == M_IDLE) & (master_state == M_SETUP);
        f.tr_setup_access  = (exp_prev_state == M_SETUP) & (master_state == M_ACCESS);
        f.tr_access_idle   = (exp_prev_state == M_ACCESS) & (master_state == M_IDLE);
        exp_fsm = exp_fsm | f;
        exp_prev_state = master_state;
        if (master_state == M_IDLE) begin
            exp_idle = exp_idle + 1;
        end else if (master_state == M_SETUP) begin
            exp_setup = exp_setup + 1;
        end else if (master_state == M_ACCESS) begin
            exp_access = exp_access + 1;
        end

        now_bits = {PSEL, PENABLE, PWRITE, start_calculation, calculation_done};
        t.psel_rise    = now_bits[4] & ~exp_prev_bits[4];
        t.psel_fall    = ~now_bits[4] & exp_prev_bits[4];
        t.penable_rise = now_bits[3] & ~exp_prev_bits[3];
        t.penable_fall = ~now_bits[3] & exp_prev_bits[3];
        t.pwrite_rise  = now_bits[2] & ~exp_prev_bits[2];
        t.pwrite_fall  = ~now_bits[2] & exp_prev_bits[2];
        t.start_rise   = now_bits[1] & ~exp_prev_bits[1];
        t.start_fall   = ~now_bits[1] & exp_prev_bits[1];
        t.done_rise    = now_bits[0] & ~exp_prev_bits[0];
        t.done_fall    = ~now_bits[0] & exp_prev_bits[0];
        exp_tog = exp_tog | t;
        exp_prev_bits = now_bits;
    endfunction

    // Outputs still hold the previous edge's result here
    always @(posedge PCLK) begin
        if (model_live) begin
            compare_apb_hits(apb_hits, exp_apb);
            compare_fsm_hits(fsm_hits, exp_fsm);
            compare_toggle_hits(toggle_hits, exp_tog);
            compare_cycles("idle_cycles", idle_cycles, exp_idle);
            compare_cycles("setup_cycles", setup_cycles, exp_setup);
            compare_cycles("access_cycles", access_cycles, exp_access);
            compare_count(covered, exp_covered);
            compare_flag("complete", complete, exp_covered == cov_count_t'(BIN_TOTAL));
        end
        if (!PRESETn) begin
            model_reset();
            model_live = 1'b1;
        end else begin
            model_step();
        end
    end

    task automatic apply_reset();
        @(negedge PCLK);
        PRESETn = 1'b0;
        repeat (5) @(negedge PCLK);
        // Everything must read zero before release
        compare_apb_hits(apb_hits, '0);
        compare_fsm_hits(fsm_hits, '0);
        compare_toggle_hits(toggle_hits, '0);
        compare_cycles("idle_cycles", idle_cycles, '0);
        compare_cycles("setup_cycles", setup_cycles, '0);
        compare_cycles("access_cycles", access_cycles, '0);
        compare_count(covered, '0);
        PRESETn = 1'b1;
    endtask

    // Master walks IDLE, SETUP, ACCESS, IDLE around each transfer
    task automatic apb_transfer(logic write, addr_t addr, data_t data);
        @(negedge PCLK);
        master_state       = M_IDLE;
        transaction_active = 1'b1;
        @(negedge PCLK);
        master_state = M_SETUP;
        PSEL         = 1'b1;
        PENABLE      = 1'b0;
        PWRITE       = write;
        PADDR        = addr;
        PWDATA       = data;
        @(negedge PCLK);
        master_state = M_ACCESS;
        PENABLE      = 1'b1;
        PREADY       = 1'b1;
        @(negedge PCLK);
        master_state       = M_IDLE;
        transaction_active = 1'b0;
        PSEL               = 1'b0;
        PENABLE            = 1'b0;
        PREADY             = 1'b0;
    endtask

    task automatic walk_registers(logic write, data_t data);
        for (int i = 0; i < 4; i++) begin
            apb_transfer(write, addr_t'(4 * i), data);
        end
        apb_transfer(write, ADDR_COS_CTRL, data);
        apb_transfer(write, ADDR_COS_DATA, data);
        apb_transfer(write, ADDR_COS_STATUS, data);
    endtask

    // done goes first so fn_cos_calc must wait for done to drop
    task automatic cos_pulse();
        @(negedge PCLK);
        cos_data_reg     = COS_PLUS_ONE;
        calculation_done = 1'b1;
        @(negedge PCLK);
        start_calculation = 1'b1;
        @(negedge PCLK);
        calculation_done = 1'b0;
        @(negedge PCLK);
        start_calculation = 1'b0;
        cos_data_reg      = COS_MINUS_ONE;
        @(negedge PCLK);
        cos_data_reg = 32'h0;
    endtask

    task automatic random_phase(int cycles);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            @(negedge PCLK);
            r = $random(seed);
            PSEL               = r[0];
            PENABLE            = r[1];
            PWRITE             = r[2];
            PREADY             = r[3];
            start_calculation  = r[4];
            calculation_done   = r[5];
            master_state       = r[7:6];
            transaction_active = r[8];
            PADDR              = {24'h0, 2'b00, r[13], 1'b0, r[11:10], 2'b00};
            PWDATA             = $random(seed);
            if (r[17:16] == 2'd0) begin
                cos_data_reg = COS_PLUS_ONE;
            end else if (r[17:16] == 2'd1) begin
                cos_data_reg = COS_MINUS_ONE;
            end else begin
                cos_data_reg = $random(seed);
            end
        end
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PREADY  = 1'b0;
    endtask

    task automatic wait_for_complete(int limit);
        int cycles;
        cycles = 0;
        while (complete !== 1'b1) begin
            if (cycles >= limit) begin
                $display("Timeout: coverage never completed within %0d cycles", limit);
                stop_run();
            end
            @(negedge PCLK);
            cycles++;
        end
    endtask

    initial begin
        seed               = 32'hfdfe687b;
        model_live         = 1'b0;
        PCLK               = 1'b0;
        PRESETn            = 1'b0;
        PSEL               = 1'b0;
        PENABLE            = 1'b0;
        PWRITE             = 1'b0;
        PADDR              = '0;
        PWDATA             = '0;
        PREADY             = 1'b0;
        cos_data_reg       = '0;
        start_calculation  = 1'b0;
        calculation_done   = 1'b0;
        master_state       = M_IDLE;
        transaction_active = 1'b0;

        apply_reset();
        walk_registers(1'b1, 32'h0);
        walk_registers(1'b1, 32'hFFFF_FFFF);
        walk_registers(1'b0, 32'h0);
        cos_pulse();
        wait_for_complete(20);

        // Clear mid-run and rebuild
        apply_reset();
        random_phase(300);
        walk_registers(1'b1, 32'hFFFF_FFFF);
        walk_registers(1'b0, 32'h0);
        cos_pulse();
        wait_for_complete(20);
        repeat (3) @(negedge PCLK);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
source/cov_pkg.sv
source/apb_access_bins.sv
source/master_fsm_bins.sv
source/toggle_bins.sv
source/coverage_tally.sv
source/coverage_collector.sv
testbench/tb_coverage_collector.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_coverage_collector
RTL_TOP    = coverage_collector
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = ALL TESTS PASSED
VFLAGS     = --binary --timing -Mdir $(BUILD_DIR) --top-module $(TOP)
LINT_FLAGS = --lint-only --timing --top-module $(RTL_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
